//--- common/trc_arb_consts.svh
// Trace SRAM arbiter constants
// Bus widths, SRAM geometry and sideband size shared by RTL and testbench

`ifndef TRC_ARB_CONSTS_SVH
`define TRC_ARB_CONSTS_SVH

// --------------------
// AHB-Lite side
`define TRC_AHB_AW      32      // Address width
`define TRC_AHB_DW      32      // Data width
`define TRC_AUSER_W     1       // User sideband, bit 0 is the debug bit

// --------------------
// SRAM side
`define TRC_SRAM_AW     10      // Byte address width, word address is [9:2]
`define TRC_SRAM_DEPTH  256     // Words
`define TRC_BWE_W       4       // One enable per byte lane

`endif

//--- common/trc_arb_pkg.sv
// Trace SRAM arbiter types
// AHB encodings, FSM states and the packed port groups

`default_nettype none

package trc_arb_pkg;

    `include "trc_arb_consts.svh"

    // --------------------
    // AHB encodings
    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_e;

    typedef enum logic [2:0] {
        HSIZE_BYTE  = 3'b000,
        HSIZE_HALF  = 3'b001,
        HSIZE_WORD  = 3'b010,
        HSIZE_DWORD = 3'b011
    } hsize_e;

    // --------------------
    // Arbiter states, _W means SB wait, _D means SB data done
    typedef enum logic [3:0] {
        IDLE             = 4'd0,
        SB_ERROR_W       = 4'd1,
        SB_ERROR_D       = 4'd2,
        TE_WR_SB_ERROR_D = 4'd3,
        SB_WRITE_D       = 4'd4,
        TE_WR_SB_SKID_W  = 4'd5,
        SB_READ_W        = 4'd6,
        TE_WR_SB_READ_D  = 4'd7,
        SB_READ_D        = 4'd8,
        TE_WRITE_D       = 4'd9
    } arb_state_e;

    typedef logic [`TRC_AHB_AW-1:0] ahb_addr_t;
    typedef logic [`TRC_AHB_DW-1:0] ahb_data_t;
    typedef logic [`TRC_BWE_W-1:0]  bwe_t;

    // --------------------
    // Port groups
    typedef struct packed {
        ahb_addr_t               haddr;
        hsize_e                  hsize;
        logic                    hwrite;
        logic [`TRC_AUSER_W-1:0] hauser;
    } ahb_req_t;

    typedef struct packed {
        logic                      ce;
        bwe_t                      bwe;
        logic [`TRC_SRAM_AW-1:2]   addr;   // Word address
        ahb_data_t                 wdata;
    } sram_cmd_t;

    typedef struct packed {
        logic      hready;
        logic      hresp;
        ahb_data_t hrdata;
    } sb_resp_t;

endpackage

`default_nettype wire

//--- trc_arb/trc_arb_req.sv
// Trace SRAM arbiter request stage
// Decodes TE and SB address phases, parks a colliding SB phase in a skid
// register and selects the active request with its byte enables

`default_nettype none

`include "trc_arb_consts.svh"

module trc_arb_req (
    input  wire                         clk_i,
    input  wire                         rst_ni,

    // TE address phase
    input  trc_arb_pkg::htrans_e        te_htrans_i,
    input  trc_arb_pkg::ahb_req_t       te_req_i,

    // SB address phase
    input  wire                         sb_hsel_i,
    input  wire                         sb_hready_i,
    input  trc_arb_pkg::htrans_e        sb_htrans_i,
    input  trc_arb_pkg::ahb_req_t       sb_req_i,

    input  wire                         mode_dbgpriv_i,   // SB needs debug bit
    input  wire                         state_en_i,       // Gate from the FSM

    output logic                        te_req_o,
    output logic                        sb_req_o,
    output logic                        any_req_o,
    output trc_arb_pkg::ahb_req_t       sel_req_o,
    output trc_arb_pkg::bwe_t           sel_bwe_o,
    output logic                        priv_err_o
);

    import trc_arb_pkg::*;

    logic     te_vld;
    logic     sb_vld;
    logic     skid_vld_q;
    logic     skid_vld_d;
    logic     skid_load;
    ahb_req_t skid_q;
    logic     sel_is_sb;

    // --------------------
    // Request decode
    assign te_vld = (te_htrans_i == HTRANS_NONSEQ) || (te_htrans_i == HTRANS_SEQ);
    assign sb_vld = sb_hsel_i && sb_hready_i &&
                    ((sb_htrans_i == HTRANS_NONSEQ) || (sb_htrans_i == HTRANS_SEQ));

    assign te_req_o  = te_vld;
    assign sb_req_o  = sb_vld;
    assign any_req_o = te_vld | sb_vld | skid_vld_q;

    // --------------------
    // Skid buffer
    // Full after a collision, stays full while TE keeps winning
    assign skid_vld_d = te_vld & (sb_vld | skid_vld_q);
    assign skid_load  = te_vld & sb_vld & ~skid_vld_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            skid_vld_q <= 1'b0;
        end else if (state_en_i) begin
            skid_vld_q <= skid_vld_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (skid_load) begin
            skid_q <= sb_req_i;     // Parked SB address phase
        end
    end

    // --------------------
    // Selection, TE then skid then live SB
    always_comb begin
        sel_req_o = '0;
        sel_is_sb = 1'b0;
        if (te_vld) begin
            sel_req_o = te_req_i;
        end else if (skid_vld_q) begin
            sel_req_o = skid_q;
            sel_is_sb = 1'b1;
        end else if (sb_vld) begin
            sel_req_o = sb_req_i;
            sel_is_sb = 1'b1;
        end
    end

    // Debug privilege only applies to SB transfers
    assign priv_err_o = sel_is_sb & mode_dbgpriv_i & ~sel_req_o.hauser[0];

    // --------------------
    // Byte enables from size and low address bits
    always_comb begin
        sel_bwe_o = '0;             // Reads touch no lane
        if (sel_req_o.hwrite) begin
            case (sel_req_o.hsize)
                HSIZE_BYTE: sel_bwe_o = bwe_t'(4'b0001) << sel_req_o.haddr[1:0];
                HSIZE_HALF: sel_bwe_o = sel_req_o.haddr[1] ? 4'b1100 : 4'b0011;
                HSIZE_WORD,
                HSIZE_DWORD: sel_bwe_o = 4'b1111;
                default: sel_bwe_o = 4'b1111;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- trc_arb/trc_arb_fsm.sv
// Trace SRAM arbiter state machine
// Sequences SRAM cycles and SB responses, state decoded straight to outputs

`default_nettype none

`include "trc_arb_consts.svh"

module trc_arb_fsm (
    input  wire                         clk_i,
    input  wire                         rst_ni,

    input  wire                         te_req_i,
    input  wire                         sb_req_i,
    input  wire                         any_req_i,
    input  trc_arb_pkg::ahb_req_t       sel_req_i,
    input  trc_arb_pkg::bwe_t           sel_bwe_i,
    input  wire                         priv_err_i,

    input  trc_arb_pkg::ahb_data_t      te_hwdata_i,    // TE data phase
    input  trc_arb_pkg::ahb_data_t      sb_hwdata_i,    // SB data phase
    input  trc_arb_pkg::ahb_data_t      sram_rdata_i,   // One cycle after read

    output logic                        state_en_o,
    output trc_arb_pkg::sram_cmd_t      sram_o,
    output trc_arb_pkg::sb_resp_t       sb_resp_o
);

    import trc_arb_pkg::*;

    arb_state_e                 state_q;
    arb_state_e                 state_d;
    logic                       state_en;
    logic                       sb_pend;
    logic [`TRC_SRAM_AW-1:2]    addr_q;
    bwe_t                       bwe_q;

    // State register only toggles when there is work
    assign state_en   = (state_q != IDLE) | any_req_i;
    assign state_en_o = state_en;

    // SB side has a live request or a parked one
    assign sb_pend = sb_req_i | (state_q == TE_WR_SB_SKID_W);

    // --------------------
    // Next state
    always_comb begin
        state_d = IDLE;
        case (state_q)
            SB_ERROR_W: begin
                state_d = te_req_i ? TE_WR_SB_ERROR_D : SB_ERROR_D;
            end
            SB_READ_W: begin
                state_d = te_req_i ? TE_WR_SB_READ_D : SB_READ_D;
            end
            default: begin
                // Accepting states, TE always wins the SRAM
                if (te_req_i) begin
                    state_d = sb_pend ? TE_WR_SB_SKID_W : TE_WRITE_D;
                end else if (sb_pend) begin
                    if (priv_err_i) begin
                        state_d = SB_ERROR_W;
                    end else if (sel_req_i.hwrite) begin
                        state_d = SB_WRITE_D;
                    end else begin
                        state_d = SB_READ_W;
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else if (state_en) begin
            state_q <= state_d;
        end
    end

    // --------------------
    // Address phase capture for the SRAM cycle
    always_ff @(posedge clk_i) begin
        if (any_req_i && !priv_err_i) begin
            addr_q <= sel_req_i.haddr[`TRC_SRAM_AW-1:2];
            bwe_q  <= sel_bwe_i;
        end
    end

    // --------------------
    // Output steering
    always_comb begin
        sram_o           = '0;
        sb_resp_o.hready = 1'b1;
        sb_resp_o.hresp  = 1'b0;
        sb_resp_o.hrdata = '0;
        case (state_q)
            SB_ERROR_W: begin
                sb_resp_o.hready = 1'b0;    // First error cycle
                sb_resp_o.hresp  = 1'b1;
            end
            SB_ERROR_D: begin
                sb_resp_o.hresp = 1'b1;
            end
            TE_WR_SB_ERROR_D: begin
                sb_resp_o.hresp = 1'b1;
                sram_o.ce       = 1'b1;
                sram_o.bwe      = bwe_q;
                sram_o.addr     = addr_q;
                sram_o.wdata    = te_hwdata_i;
            end
            SB_WRITE_D: begin
                sram_o.ce    = 1'b1;
                sram_o.bwe   = bwe_q;
                sram_o.addr  = addr_q;
                sram_o.wdata = sb_hwdata_i;
            end
            TE_WR_SB_SKID_W: begin
                sb_resp_o.hready = 1'b0;    // SB waits behind TE
                sram_o.ce        = 1'b1;
                sram_o.bwe       = bwe_q;
                sram_o.addr      = addr_q;
                sram_o.wdata     = te_hwdata_i;
            end
            SB_READ_W: begin
                sb_resp_o.hready = 1'b0;
                sram_o.ce        = 1'b1;    // Read, bwe_q is zero
                sram_o.bwe       = bwe_q;
                sram_o.addr      = addr_q;
            end
            TE_WR_SB_READ_D: begin
                sb_resp_o.hrdata = sram_rdata_i;
                sram_o.ce        = 1'b1;
                sram_o.bwe       = bwe_q;
                sram_o.addr      = addr_q;
                sram_o.wdata     = te_hwdata_i;
            end
            SB_READ_D: begin
                sb_resp_o.hrdata = sram_rdata_i;
            end
            TE_WRITE_D: begin
                sram_o.ce    = 1'b1;
                sram_o.bwe   = bwe_q;
                sram_o.addr  = addr_q;
                sram_o.wdata = te_hwdata_i;
            end
            default: ;                      // IDLE, ready and quiet
        endcase
    end

endmodule

`default_nettype wire

//--- trc_arb/trc_arb_top.sv
// Trace SRAM arbiter
// Shares one single-port trace SRAM between the TE and SB AHB-Lite ports

`default_nettype none

`include "trc_arb_consts.svh"

module trc_arb_top (
    input  wire                         clk_i,
    input  wire                         rst_ni,

    // TE port, write only
    input  trc_arb_pkg::htrans_e        te_htrans_i,
    input  trc_arb_pkg::hsize_e         te_hsize_i,
    input  trc_arb_pkg::ahb_addr_t      te_haddr_i,
    input  wire [`TRC_AUSER_W-1:0]      te_hauser_i,
    input  trc_arb_pkg::ahb_data_t      te_hwdata_i,

    // SB port
    input  wire                         sb_hsel_i,
    input  wire                         sb_hready_i,
    input  trc_arb_pkg::htrans_e        sb_htrans_i,
    input  trc_arb_pkg::hsize_e         sb_hsize_i,
    input  wire                         sb_hwrite_i,
    input  trc_arb_pkg::ahb_addr_t      sb_haddr_i,
    input  wire [`TRC_AUSER_W-1:0]      sb_hauser_i,
    input  trc_arb_pkg::ahb_data_t      sb_hwdata_i,
    output logic                        sb_hready_o,
    output logic                        sb_hresp_o,
    output trc_arb_pkg::ahb_data_t      sb_hrdata_o,

    // SRAM
    output logic                        sram_ce_o,
    output trc_arb_pkg::bwe_t           sram_bwe_o,
    output logic [`TRC_SRAM_AW-1:2]     sram_addr_o,
    output trc_arb_pkg::ahb_data_t      sram_wdata_o,
    input  trc_arb_pkg::ahb_data_t      sram_rdata_i,

    input  wire                         mode_dbgpriv_i
);

    import trc_arb_pkg::*;

    ahb_req_t  te_req;
    ahb_req_t  sb_req;
    ahb_req_t  sel_req;
    bwe_t      sel_bwe;
    logic      te_req_vld;
    logic      sb_req_vld;
    logic      any_req;
    logic      priv_err;
    logic      state_en;
    sram_cmd_t sram_cmd;
    sb_resp_t  sb_resp;

    // --------------------
    // Port packing
    assign te_req = '{haddr: te_haddr_i, hsize: te_hsize_i, hwrite: 1'b1, hauser: te_hauser_i};
    assign sb_req = '{haddr: sb_haddr_i, hsize: sb_hsize_i, hwrite: sb_hwrite_i,
                      hauser: sb_hauser_i};

    trc_arb_req u_req (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .te_htrans_i    (te_htrans_i),
        .te_req_i       (te_req),
        .sb_hsel_i      (sb_hsel_i),
        .sb_hready_i    (sb_hready_i),
        .sb_htrans_i    (sb_htrans_i),
        .sb_req_i       (sb_req),
        .mode_dbgpriv_i (mode_dbgpriv_i),
        .state_en_i     (state_en),
        .te_req_o       (te_req_vld),
        .sb_req_o       (sb_req_vld),
        .any_req_o      (any_req),
        .sel_req_o      (sel_req),
        .sel_bwe_o      (sel_bwe),
        .priv_err_o     (priv_err)
    );

    trc_arb_fsm u_fsm (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .te_req_i       (te_req_vld),
        .sb_req_i       (sb_req_vld),
        .any_req_i      (any_req),
        .sel_req_i      (sel_req),
        .sel_bwe_i      (sel_bwe),
        .priv_err_i     (priv_err),
        .te_hwdata_i    (te_hwdata_i),
        .sb_hwdata_i    (sb_hwdata_i),
        .sram_rdata_i   (sram_rdata_i),
        .state_en_o     (state_en),
        .sram_o         (sram_cmd),
        .sb_resp_o      (sb_resp)
    );

    // --------------------
    // Port unpacking
    assign sram_ce_o    = sram_cmd.ce;
    assign sram_bwe_o   = sram_cmd.bwe;
    assign sram_addr_o  = sram_cmd.addr;
    assign sram_wdata_o = sram_cmd.wdata;

    assign sb_hready_o  = sb_resp.hready;
    assign sb_hresp_o   = sb_resp.hresp;
    assign sb_hrdata_o  = sb_resp.hrdata;

endmodule

`default_nettype wire

//--- tb/trc_arb_clkgen.sv
// Testbench clock and reset
// 40 ns clock, active low reset held for two cycles

`default_nettype none

module trc_arb_clkgen (
    output logic clk_o,
    output logic rst_no
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o  = 1'b0;
        rst_no = 1'b0;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

    always #20 clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- tb/trc_sram_model.sv
// Trace SRAM model
// 256 words with byte enables, read data registered one cycle

`default_nettype none

`include "trc_arb_consts.svh"

module trc_sram_model (
    input  wire                          clk_i,
    input  wire                          ce_i,
    input  trc_arb_pkg::bwe_t            bwe_i,
    input  wire [`TRC_SRAM_AW-1:2]       addr_i,
    input  trc_arb_pkg::ahb_data_t       wdata_i,
    output trc_arb_pkg::ahb_data_t       rdata_o
);

    timeunit 1ns;
    timeprecision 100ps;

    import trc_arb_pkg::*;

    ahb_data_t mem [`TRC_SRAM_DEPTH];

    initial begin
        for (int i = 0; i < `TRC_SRAM_DEPTH; i++) begin
            mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'hA5, 8'h3C};  // Per-word fill
        end
        rdata_o = '0;
    end

    always @(posedge clk_i) begin
        if (ce_i) begin
            rdata_o <= mem[addr_i];     // Old data on a write cycle
            for (int b = 0; b < `TRC_BWE_W; b++) begin
                if (bwe_i[b]) mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/trc_arb_checker.sv
// Arbiter FSM assertions
// Error sequencing and idle behaviour checks bound into trc_arb_fsm

`default_nettype none

module trc_arb_checker (
    input wire                        clk_i,
    input wire                        rst_ni,
    input trc_arb_pkg::arb_state_e    state_i,
    input wire                        ce_i,
    input wire                        hready_i,
    input wire                        hresp_i
);

    timeunit 1ns;
    timeprecision 100ps;

    import trc_arb_pkg::*;

    int fail_cnt = 0;   // Failed assertions so far

    // SRAM stays quiet during an SB error
    a_err_no_ce: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (state_i == SB_ERROR_W || state_i == SB_ERROR_D) |-> !ce_i)
        else begin
            fail_cnt++;
            $error("SRAM enabled during SB error");
        end

    // Two-cycle ERROR response
    a_err_two_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (hresp_i && !hready_i) |=> (hresp_i && hready_i))
        else begin
            fail_cnt++;
            $error("SB error response missing its second cycle");
        end

    a_idle_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (state_i == IDLE) |-> hready_i)
        else begin
            fail_cnt++;
            $error("SB not ready in IDLE");
        end

endmodule

bind trc_arb_fsm trc_arb_checker u_chk (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .state_i  (state_q),
    .ce_i     (sram_o.ce),
    .hready_i (sb_resp_o.hready),
    .hresp_i  (sb_resp_o.hresp)
);

`default_nettype wire

//--- tb/trc_arb_tb.sv
// Trace SRAM arbiter testbench
// Directed SB, TE, collision and privilege tests against a reference memory

`default_nettype none

`include "trc_arb_consts.svh"

module trc_arb_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import trc_arb_pkg::*;

    logic clk, rst_n;
    htrans_e te_htrans, sb_htrans;
    hsize_e te_hsize, sb_hsize;
    ahb_addr_t te_haddr, sb_haddr;
    ahb_data_t te_hwdata, sb_hwdata, sb_hrdata, sram_wdata, sram_rdata;
    logic [`TRC_AUSER_W-1:0] te_hauser, sb_hauser;
    logic sb_hsel, sb_hwrite, sb_hready, sb_hresp, sram_ce, mode_dbgpriv;
    bwe_t sram_bwe;
    logic [`TRC_SRAM_AW-1:2] sram_addr;

    ahb_data_t ref_mem [`TRC_SRAM_DEPTH];
    integer seed = 91075;
    int err_data = 0;
    int err_resp = 0;
    int err_other = 0;

    trc_arb_clkgen u_clk (.clk_o(clk), .rst_no(rst_n));

    trc_arb_top uut (
        .clk_i(clk), .rst_ni(rst_n),
        .te_htrans_i(te_htrans), .te_hsize_i(te_hsize), .te_haddr_i(te_haddr),
        .te_hauser_i(te_hauser), .te_hwdata_i(te_hwdata),
        .sb_hsel_i(sb_hsel), .sb_hready_i(sb_hready), .sb_htrans_i(sb_htrans),
        .sb_hsize_i(sb_hsize), .sb_hwrite_i(sb_hwrite), .sb_haddr_i(sb_haddr),
        .sb_hauser_i(sb_hauser), .sb_hwdata_i(sb_hwdata),
        .sb_hready_o(sb_hready), .sb_hresp_o(sb_hresp), .sb_hrdata_o(sb_hrdata),
        .sram_ce_o(sram_ce), .sram_bwe_o(sram_bwe), .sram_addr_o(sram_addr),
        .sram_wdata_o(sram_wdata), .sram_rdata_i(sram_rdata),
        .mode_dbgpriv_i(mode_dbgpriv)
    );

    trc_sram_model u_sram (
        .clk_i(clk), .ce_i(sram_ce), .bwe_i(sram_bwe), .addr_i(sram_addr),
        .wdata_i(sram_wdata), .rdata_o(sram_rdata)
    );

    // --------------------
    // Compare tasks
    task automatic check_data(input string name, input ahb_data_t got, input ahb_data_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp);
            err_data++;
        end
    endtask

    task automatic check_resp(input string name, input sb_resp_t got, input sb_resp_t exp);
        if (got.hready !== exp.hready || got.hresp !== exp.hresp) begin
            $display("MISMATCH %s sb_hready_o/sb_hresp_o got 0x%0h/0x%0h expected 0x%0h/0x%0h",
                     name, got.hready, got.hresp, exp.hready, exp.hresp);
            err_resp++;
        end
    endtask

    task automatic check_latency(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("%s finished after %0d cycles instead of %0d", name, got, exp);
            err_other++;
        end
    endtask

    function automatic sb_resp_t resp_of(input logic rdy, input logic err);
        sb_resp_t r;
        r = '0;
        r.hready = rdy;
        r.hresp  = err;
        return r;
    endfunction

    // Reference update with lanes picked by size and low address bits
    task automatic ref_write(input hsize_e sz, input ahb_addr_t a, input ahb_data_t d);
        bwe_t m;
        case (sz)
            HSIZE_BYTE: m = bwe_t'(1 << a[1:0]);
            HSIZE_HALF: m = a[1] ? 4'b1100 : 4'b0011;
            default:    m = 4'b1111;
        endcase
        for (int b = 0; b < 4; b++) begin
            if (m[b]) ref_mem[a[9:2]][b*8 +: 8] = d[b*8 +: 8];
        end
    endtask

    function automatic ahb_addr_t rand_addr(input hsize_e sz);
        ahb_addr_t a;
        a = ahb_addr_t'($random(seed)) & 32'h0000_03FF;
        if (sz == HSIZE_HALF) a[0] = 1'b0;
        if (sz == HSIZE_WORD) a[1:0] = 2'b00;
        return a;
    endfunction

    // --------------------
    // Bus drivers
    task automatic sb_xfer(input logic wr, input hsize_e sz, input ahb_addr_t a,
                           input ahb_data_t wd, input logic usr, input logic te_on,
                           input ahb_addr_t te_a, input ahb_data_t te_d,
                           output sb_resp_t rsp, output int lat);
        @(negedge clk);
        sb_hsel   = 1'b1;
        sb_htrans = HTRANS_NONSEQ;
        sb_hwrite = wr;
        sb_hsize  = sz;
        sb_haddr  = a;
        sb_hauser = usr;
        if (te_on) begin
            te_htrans = HTRANS_NONSEQ;
            te_hsize  = HSIZE_WORD;
            te_haddr  = te_a;
        end
        @(negedge clk);
        sb_htrans = HTRANS_IDLE;
        te_htrans = HTRANS_IDLE;
        sb_hwdata = wd;                 // Data phase
        te_hwdata = te_d;
        lat = 1;
        while (!sb_hready && lat < 20) begin
            @(negedge clk);
            lat++;
        end
        if (!sb_hready) begin
            $display("SB transfer at 0x%08h got no response", a);
            err_other++;
        end
        rsp = '{hready: sb_hready, hresp: sb_hresp, hrdata: sb_hrdata};
    endtask

    task automatic sb_write_ok(input hsize_e sz, input ahb_addr_t a, input ahb_data_t d);
        sb_resp_t rsp;
        int lat;
        sb_xfer(1'b1, sz, a, d, 1'b1, 1'b0, '0, '0, rsp, lat);
        check_resp("sb_write", rsp, resp_of(1'b1, 1'b0));
        check_latency("SB write", lat, 1);
        ref_write(sz, a, d);
    endtask

    task automatic sb_read_ok(input ahb_addr_t a);
        sb_resp_t rsp;
        int lat;
        sb_xfer(1'b0, HSIZE_WORD, a & ~32'h3, '0, 1'b1, 1'b0, '0, '0, rsp, lat);
        check_resp("sb_read", rsp, resp_of(1'b1, 1'b0));
        check_latency("SB read", lat, 2);
        check_data("sb_hrdata_o", rsp.hrdata, ref_mem[a[9:2]]);
    endtask

    task automatic te_write(input hsize_e sz, input ahb_addr_t a, input ahb_data_t d);
        @(negedge clk);
        te_htrans = HTRANS_NONSEQ;
        te_hsize  = sz;
        te_haddr  = a;
        @(negedge clk);
        te_htrans = HTRANS_IDLE;
        te_hwdata = d;
        @(negedge clk);                 // SRAM write has landed
        ref_write(sz, a, d);
    endtask

    // --------------------
    // Directed tests
    task automatic test_reset();
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("Reset never released");
            err_other++;
        end
        check_resp("reset", '{hready: sb_hready, hresp: sb_hresp, hrdata: '0},
                   resp_of(1'b1, 1'b0));
        if (sram_ce !== 1'b0) begin
            $display("MISMATCH sram_ce_o got 0x%0h expected 0x0", sram_ce);
            err_data++;
        end
    endtask

    task automatic test_sb_rw();
        ahb_addr_t a;
        for (int i = 0; i < 6; i++) begin
            a = rand_addr(HSIZE_WORD);
            sb_write_ok(HSIZE_WORD, a, $random(seed));
            sb_read_ok(a);
            a = rand_addr(HSIZE_HALF);
            sb_write_ok(HSIZE_HALF, a, $random(seed));
            sb_read_ok(a);
            a = rand_addr(HSIZE_BYTE);
            sb_write_ok(HSIZE_BYTE, a, $random(seed));
            sb_read_ok(a);
        end
    endtask

    task automatic test_te_write();
        ahb_addr_t a;
        for (int i = 0; i < 4; i++) begin
            a = rand_addr(HSIZE_WORD);
            te_write(HSIZE_WORD, a, $random(seed));
            sb_read_ok(a);
            a = rand_addr(HSIZE_BYTE);
            te_write(HSIZE_BYTE, a, $random(seed));
            sb_read_ok(a);
        end
    endtask

    task automatic test_collision();
        sb_resp_t rsp;
        int lat;
        ahb_data_t td, sd;
        td = $random(seed);
        sd = $random(seed);
        // SB write behind a TE write
        sb_xfer(1'b1, HSIZE_WORD, 32'h100, sd, 1'b1, 1'b1, 32'h200, td, rsp, lat);
        check_resp("collide_write", rsp, resp_of(1'b1, 1'b0));
        check_latency("Colliding SB write", lat, 2);
        ref_write(HSIZE_WORD, 32'h200, td);
        ref_write(HSIZE_WORD, 32'h100, sd);
        sb_read_ok(32'h100);
        sb_read_ok(32'h200);
        // SB read behind a TE write
        td = $random(seed);
        sb_xfer(1'b0, HSIZE_WORD, 32'h100, '0, 1'b1, 1'b1, 32'h204, td, rsp, lat);
        check_resp("collide_read", rsp, resp_of(1'b1, 1'b0));
        check_latency("Colliding SB read", lat, 3);
        check_data("sb_hrdata_o", rsp.hrdata, ref_mem[8'h40]);
        ref_write(HSIZE_WORD, 32'h204, td);
        sb_read_ok(32'h204);
    endtask

    task automatic test_priv();
        sb_resp_t rsp;
        int lat;
        mode_dbgpriv = 1'b1;
        sb_xfer(1'b1, HSIZE_WORD, 32'h300, 32'hDEAD_BEEF, 1'b0, 1'b0, '0, '0, rsp, lat);
        check_resp("priv_error", rsp, resp_of(1'b1, 1'b1));
        check_latency("SB error", lat, 2);
        sb_read_ok(32'h300);                        // Memory untouched
        sb_write_ok(HSIZE_WORD, 32'h300, 32'h1234_5678);
        sb_read_ok(32'h300);
        mode_dbgpriv = 1'b0;
        sb_xfer(1'b1, HSIZE_WORD, 32'h304, 32'hCAFE_F00D, 1'b0, 1'b0, '0, '0, rsp, lat);
        check_resp("priv_off", rsp, resp_of(1'b1, 1'b0));
        ref_write(HSIZE_WORD, 32'h304, 32'hCAFE_F00D);
        sb_read_ok(32'h304);
    endtask

    initial begin
        te_htrans = HTRANS_IDLE;
        te_hsize  = HSIZE_WORD;
        te_haddr  = '0;
        te_hauser = '0;
        te_hwdata = '0;
        sb_hsel   = 1'b0;
        sb_htrans = HTRANS_IDLE;
        sb_hsize  = HSIZE_WORD;
        sb_hwrite = 1'b0;
        sb_haddr  = '0;
        sb_hauser = '0;
        sb_hwdata = '0;
        mode_dbgpriv = 1'b0;
        for (int i = 0; i < `TRC_SRAM_DEPTH; i++) begin
            ref_mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'hA5, 8'h3C};
        end

        test_reset();
        test_sb_rw();
        test_te_write();
        test_collision();
        test_priv();

        $display("errors: data=%0d resp=%0d other=%0d assert=%0d",
                 err_data, err_resp, err_other, uut.u_fsm.u_chk.fail_cnt);
        if (err_data + err_resp + err_other + uut.u_fsm.u_chk.fail_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+common
common/trc_arb_pkg.sv
trc_arb/trc_arb_req.sv
trc_arb/trc_arb_fsm.sv
trc_arb/trc_arb_top.sv
tb/trc_arb_clkgen.sv
tb/trc_sram_model.sv
tb/trc_arb_checker.sv
tb/trc_arb_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the trace SRAM arbiter testbench with Verilator

verilator --binary --timing -f files.f --top-module trc_arb_tb \
    -Mdir obj_dir -o trc_arb_sim > build.log 2>&1 \
    || { cat build.log; exit 1; }

./obj_dir/trc_arb_sim > sim.log 2>&1
cat sim.log

grep -q "STATUS: FAIL" sim.log && exit 1 || grep -q "STATUS: PASS" sim.log
